/* rtl/sort_settings.svh */
// Packet sorter build constants
// Word width, bank depth, bank count and register address width
`ifndef SORT_SETTINGS_SVH
`define SORT_SETTINGS_SVH

// Data word width in bits
`define SORT_W 16

// Words per bank, longer packets are cut here
`define SORT_N 8

// Storage banks, visited round-robin
`define SORT_BANKS 2

// Register word address width
`define CSR_AW 4

`endif

/* rtl/sort_pkg.sv */
// Packet sorter datapath types
// Data word, bank address, bank id and the bank status encoding

`include "sort_settings.svh"

package sort_pkg;

  // Index width inside one bank
  localparam int AW = $clog2(`SORT_N);

  // Bank id width, never narrower than one bit
  localparam int BW = (`SORT_BANKS > 1) ? $clog2(`SORT_BANKS) : 1;

  typedef logic [`SORT_W-1:0] w_t;
  typedef logic [AW-1:0] addr_t;

  // Index of the last stored word
  typedef logic [AW-1:0] len_t;

  typedef logic [BW-1:0] bank_id_t;

  // Life cycle of one bank
  typedef enum logic [2:0] {
    BANK_READY,
    BANK_FILLING,
    BANK_FULL,
    BANK_SORTING,
    BANK_SORTED,
    BANK_UNLOADING
  } bank_status_t;

  // Next bank in round-robin order
  function automatic bank_id_t bank_id_inc(bank_id_t id);
    if (id == bank_id_t'(`SORT_BANKS - 1)) begin
      return '0;
    end
    return id + 1'b1;
  endfunction

endpackage

/* rtl/csr_pkg.sv */
// Register map of the sorter control block
// Word addresses and CTRL field positions

`include "sort_settings.svh"

package csr_pkg;

  // Word addresses on the Wishbone port
  typedef enum logic [`CSR_AW-1:0] {
    CSR_CTRL      = 0,
    CSR_STATUS    = 1,
    CSR_PKT_COUNT = 2,
    CSR_ERR_COUNT = 3
  } csr_addr_t;

  // CTRL fields
  localparam int CTRL_ENABLE_BIT  = 0;
  localparam int CTRL_DESCEND_BIT = 1;

endpackage

/* rtl/sort_enq.sv */
// Packet enqueue
// Writes accepted words into the current bank, cuts packets at the
// bank depth and reports each finished fill to the engine

`timescale 1ns/1ps

`include "sort_settings.svh"

module sort_enq (
    input  logic                                       clk
  , input  logic                                       rst_n
  , input  logic                                       enable
  , input  logic                                       in_vld
  , input  logic                                       in_sop
  , input  logic                                       in_eop
  , input  sort_pkg::w_t                               in_dat
  , input  sort_pkg::bank_status_t [`SORT_BANKS-1:0]   bank_status
  , output logic                                       in_rdy
  , output logic                                       wr_en
  , output sort_pkg::bank_id_t                         wr_bank
  , output sort_pkg::addr_t                            wr_addr
  , output sort_pkg::w_t                               wr_dat
  , output logic                                       fill_start
  , output logic                                       fill_done
  , output sort_pkg::bank_id_t                         fill_bank
  , output sort_pkg::len_t                             fill_len
  , output logic                                       fill_err
);

  sort_pkg::bank_id_t     cur_bank;
  sort_pkg::addr_t        wr_idx;
  sort_pkg::bank_status_t cur_status;
  logic                   over;
  logic                   acc;

  assign cur_status = bank_status[cur_bank];

  // Open only while the current bank can take words
  assign in_rdy = enable && (cur_status == sort_pkg::BANK_READY ||
                             cur_status == sort_pkg::BANK_FILLING);
  assign acc    = in_vld && in_rdy;

  // Index restarts on sop
  assign wr_addr = in_sop ? '0 : wr_idx;
  assign wr_bank = cur_bank;
  assign wr_dat  = in_dat;

  // Words past the bank depth are dropped
  assign wr_en = acc && (in_sop || !over);

  // Claim on sop, report on eop
  assign fill_start = acc && in_sop;
  assign fill_done  = acc && in_eop;
  assign fill_bank  = cur_bank;
  assign fill_err   = over && !in_sop;
  assign fill_len   = fill_err ? sort_pkg::len_t'(`SORT_N - 1) : wr_addr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cur_bank <= '0;
      wr_idx   <= '0;
      over     <= 1'b0;
    end else if (fill_done) begin
      // Packet closed, move to the next bank
      cur_bank <= sort_pkg::bank_id_inc(cur_bank);
      wr_idx   <= '0;
      over     <= 1'b0;
    end else if (wr_en) begin
      over   <= (wr_addr == sort_pkg::addr_t'(`SORT_N - 1));
      wr_idx <= wr_addr + 1'b1;
    end
  end

  // Only the bank being filled, or the one claimed this cycle, takes writes
  a_wr_filling : assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> (bank_status[wr_bank] == sort_pkg::BANK_FILLING) || fill_start);

endmodule

/* rtl/sort_engine.sv */
// Sort engine
// Owns the bank memories and the bank status table, and puts each
// full bank in order in place with a single compare-and-swap per cycle

`timescale 1ns/1ps

`include "sort_settings.svh"

module sort_engine (
    input  logic                                       clk
  , input  logic                                       rst_n
  , input  logic                                       descend
  , input  logic                                       wr_en
  , input  sort_pkg::bank_id_t                         wr_bank
  , input  sort_pkg::addr_t                            wr_addr
  , input  sort_pkg::w_t                               wr_dat
  , input  logic                                       fill_start
  , input  logic                                       fill_done
  , input  sort_pkg::bank_id_t                         fill_bank
  , input  sort_pkg::len_t                             fill_len
  , input  logic                                       fill_err
  , input  sort_pkg::bank_id_t                         deq_bank
  , input  logic                                       unload_start
  , input  logic                                       unload_done
  , input  logic                                       rd_en
  , input  sort_pkg::addr_t                            rd_addr
  , output sort_pkg::bank_status_t [`SORT_BANKS-1:0]   bank_status
  , output sort_pkg::w_t                               rd_dat
  , output sort_pkg::len_t                             bank_len
  , output logic                                       bank_err
);

  typedef enum logic {S_IDLE, S_RUN} sort_state_t;

  sort_pkg::w_t          mem [`SORT_BANKS][`SORT_N];
  sort_pkg::len_t        len_q [`SORT_BANKS];
  logic [`SORT_BANKS-1:0] err_q;

  sort_state_t           state;
  sort_pkg::bank_id_t    sort_bank;
  sort_pkg::addr_t       i_idx;
  sort_pkg::addr_t       j_idx;
  sort_pkg::len_t        sort_len;
  sort_pkg::w_t          dat_i;
  sort_pkg::w_t          dat_j;
  logic                  desc_q;
  logic                  sort_begin;
  logic                  sort_end;
  logic                  swap;

  // Legal steps of the bank life cycle
  // A one-word packet goes from READY straight to FULL
  function automatic logic legal_step(sort_pkg::bank_status_t cur,
                                      sort_pkg::bank_status_t nxt);
    case (cur)
      sort_pkg::BANK_READY:     return nxt == sort_pkg::BANK_FILLING ||
                                       nxt == sort_pkg::BANK_FULL;
      sort_pkg::BANK_FILLING:   return nxt == sort_pkg::BANK_FULL;
      sort_pkg::BANK_FULL:      return nxt == sort_pkg::BANK_SORTING;
      sort_pkg::BANK_SORTING:   return nxt == sort_pkg::BANK_SORTED;
      sort_pkg::BANK_SORTED:    return nxt == sort_pkg::BANK_UNLOADING;
      sort_pkg::BANK_UNLOADING: return nxt == sort_pkg::BANK_READY;
      default:                  return 1'b0;
    endcase
  endfunction

  // Pair under compare
  assign sort_len = len_q[sort_bank];
  assign dat_i    = mem[sort_bank][i_idx];
  assign dat_j    = mem[sort_bank][j_idx];

  assign sort_begin = (state == S_IDLE) &&
                      (bank_status[sort_bank] == sort_pkg::BANK_FULL);
  assign sort_end   = (state == S_RUN) && ((sort_len == '0) ||
                      (j_idx == sort_len && i_idx == sort_len - 1'b1));

  // Swap when the pair is out of the selected order
  assign swap = (state == S_RUN) && (sort_len != '0) &&
                (desc_q ? (dat_i < dat_j) : (dat_i > dat_j));

  // Exchange loop, i over 0..len-1 and j over i+1..len
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      sort_bank <= '0;
      i_idx     <= '0;
      j_idx     <= '0;
      desc_q    <= 1'b0;
    end else if (sort_begin) begin
      state  <= S_RUN;
      i_idx  <= '0;
      j_idx  <= sort_pkg::addr_t'(1);
      desc_q <= descend;
    end else if (sort_end) begin
      state     <= S_IDLE;
      sort_bank <= sort_pkg::bank_id_inc(sort_bank);
    end else if (state == S_RUN) begin
      if (j_idx == sort_len) begin
        i_idx <= i_idx + 1'b1;
        j_idx <= i_idx + 2'd2;
      end else begin
        j_idx <= j_idx + 1'b1;
      end
    end
  end

  // Status table, one writer per transition
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int b = 0; b < `SORT_BANKS; b++) begin
        bank_status[b] <= sort_pkg::BANK_READY;
      end
    end else begin
      for (int b = 0; b < `SORT_BANKS; b++) begin
        if (fill_start && fill_bank == sort_pkg::bank_id_t'(b) &&
            bank_status[b] == sort_pkg::BANK_READY) begin
          bank_status[b] <= sort_pkg::BANK_FILLING;
        end
        // Later assignment wins for a one-word packet
        if (fill_done && fill_bank == sort_pkg::bank_id_t'(b)) begin
          bank_status[b] <= sort_pkg::BANK_FULL;
        end
        if (sort_begin && sort_bank == sort_pkg::bank_id_t'(b)) begin
          bank_status[b] <= sort_pkg::BANK_SORTING;
        end
        if (sort_end && sort_bank == sort_pkg::bank_id_t'(b)) begin
          bank_status[b] <= sort_pkg::BANK_SORTED;
        end
        if (unload_start && deq_bank == sort_pkg::bank_id_t'(b)) begin
          bank_status[b] <= sort_pkg::BANK_UNLOADING;
        end
        if (unload_done && deq_bank == sort_pkg::bank_id_t'(b)) begin
          bank_status[b] <= sort_pkg::BANK_READY;
        end
      end
    end
  end

  // Enqueue and sort never touch the same bank
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_bank][wr_addr] <= wr_dat;
    end
    if (swap) begin
      mem[sort_bank][i_idx] <= dat_j;
      mem[sort_bank][j_idx] <= dat_i;
    end
    if (fill_done) begin
      len_q[fill_bank] <= fill_len;
      err_q[fill_bank] <= fill_err;
    end
    // Read data one cycle after rd_en
    if (rd_en) begin
      rd_dat <= mem[deq_bank][rd_addr];
    end
  end

  assign bank_len = len_q[deq_bank];
  assign bank_err = err_q[deq_bank];

  for (genvar b = 0; b < `SORT_BANKS; b++) begin : g_status_chk
    a_status_step : assert property (@(posedge clk) disable iff (!rst_n)
      (bank_status[b] != $past(bank_status[b])) |->
        legal_step($past(bank_status[b]), bank_status[b]));
  end

endmodule

/* rtl/sort_deq.sv */
// Packet dequeue
// Unloads sorted banks in round-robin order into the output stream
// with sop, eop and err markers lined up to the read data

`timescale 1ns/1ps

`include "sort_settings.svh"

module sort_deq (
    input  logic                                       clk
  , input  logic                                       rst_n
  , input  sort_pkg::bank_status_t [`SORT_BANKS-1:0]   bank_status
  , input  sort_pkg::w_t                               rd_dat
  , input  sort_pkg::len_t                             bank_len
  , input  logic                                       bank_err
  , output sort_pkg::bank_id_t                         deq_bank
  , output logic                                       unload_start
  , output logic                                       unload_done
  , output logic                                       rd_en
  , output sort_pkg::addr_t                            rd_addr
  , output logic                                       out_vld
  , output logic                                       out_sop
  , output logic                                       out_eop
  , output logic                                       out_err
  , output sort_pkg::w_t                               out_dat
  , output logic                                       pkt_done
  , output logic                                       pkt_err
);

  typedef enum logic {D_IDLE, D_UNLOAD} deq_state_t;

  deq_state_t      state;
  sort_pkg::addr_t idx;
  logic            last;

  // Markers staged alongside the read
  logic st_vld;
  logic st_sop;
  logic st_eop;
  logic st_err;

  assign last = (idx == bank_len);

  // Wait in IDLE for the next bank to be sorted
  assign unload_start = (state == D_IDLE) &&
                        (bank_status[deq_bank] == sort_pkg::BANK_SORTED);

  // One read per cycle while unloading
  assign rd_en   = (state == D_UNLOAD);
  assign rd_addr = idx;

  // Bank released with the eop read
  assign unload_done = rd_en && last;
  assign pkt_done    = unload_done;
  assign pkt_err     = unload_done && bank_err;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= D_IDLE;
      deq_bank <= '0;
      idx      <= '0;
    end else if (unload_start) begin
      state <= D_UNLOAD;
      idx   <= '0;
    end else if (unload_done) begin
      state    <= D_IDLE;
      deq_bank <= sort_pkg::bank_id_inc(deq_bank);
    end else if (rd_en) begin
      idx <= idx + 1'b1;
    end
  end

  // Stage then output, two cycles after the read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      st_vld  <= 1'b0;
      st_sop  <= 1'b0;
      st_eop  <= 1'b0;
      st_err  <= 1'b0;
      out_vld <= 1'b0;
      out_sop <= 1'b0;
      out_eop <= 1'b0;
      out_err <= 1'b0;
    end else begin
      st_vld  <= rd_en;
      st_sop  <= rd_en && (idx == '0);
      st_eop  <= unload_done;
      st_err  <= pkt_err;
      out_vld <= st_vld;
      out_sop <= st_sop;
      out_eop <= st_eop;
      out_err <= st_err;
    end
  end

  // Read data lands with the staged markers
  always_ff @(posedge clk) begin
    if (st_vld) begin
      out_dat <= rd_dat;
    end
  end

  a_eop_vld : assert property (@(posedge clk) disable iff (!rst_n)
    out_eop |-> out_vld);

  // Packet words are back to back up to eop
  a_no_gap : assert property (@(posedge clk) disable iff (!rst_n)
    out_vld && !out_eop |=> out_vld);

endmodule

/* rtl/sort_csr.sv */
// Sorter register block
// Wishbone classic slave with CTRL, bank status and the packet
// and error counters

`timescale 1ns/1ps

`include "sort_settings.svh"

module sort_csr (
    input  logic                                       clk
  , input  logic                                       rst_n
  , input  logic                                       wb_cyc
  , input  logic                                       wb_stb
  , input  logic                                       wb_we
  , input  logic [`CSR_AW-1:0]                         wb_adr
  , input  logic [31:0]                                wb_dat_w
  , input  sort_pkg::bank_status_t [`SORT_BANKS-1:0]   bank_status
  , input  logic                                       pkt_done
  , input  logic                                       pkt_err
  , output logic [31:0]                                wb_dat_r
  , output logic                                       wb_ack
  , output logic                                       enable
  , output logic                                       descend
);

  csr_pkg::csr_addr_t adr;
  logic               req;
  logic [31:0]        rdata;
  logic [15:0]        pkt_cnt;
  logic [15:0]        err_cnt;

  // New cycle only while ack is low
  assign req = wb_cyc && wb_stb && !wb_ack;
  assign adr = csr_pkg::csr_addr_t'(wb_adr);

  // Read mux
  always_comb begin
    rdata = '0;
    case (adr)
      csr_pkg::CSR_CTRL: begin
        rdata[csr_pkg::CTRL_ENABLE_BIT]  = enable;
        rdata[csr_pkg::CTRL_DESCEND_BIT] = descend;
      end
      // Four bits per bank
      csr_pkg::CSR_STATUS: begin
        for (int b = 0; b < `SORT_BANKS; b++) begin
          rdata[4*b +: 4] = {1'b0, bank_status[b]};
        end
      end
      csr_pkg::CSR_PKT_COUNT: rdata[15:0] = pkt_cnt;
      csr_pkg::CSR_ERR_COUNT: rdata[15:0] = err_cnt;
      default: rdata = '0;
    endcase
  end

  // Ack one cycle after the request, write on the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack  <= 1'b0;
      enable  <= 1'b0;
      descend <= 1'b0;
    end else begin
      wb_ack <= req;
      if (req && wb_we && adr == csr_pkg::CSR_CTRL) begin
        enable  <= wb_dat_w[csr_pkg::CTRL_ENABLE_BIT];
        descend <= wb_dat_w[csr_pkg::CTRL_DESCEND_BIT];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_r <= rdata;
    end
  end

  // Saturating event counters
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pkt_cnt <= '0;
      err_cnt <= '0;
    end else begin
      if (pkt_done && pkt_cnt != 16'hffff) begin
        pkt_cnt <= pkt_cnt + 1'b1;
      end
      if (pkt_err && err_cnt != 16'hffff) begin
        err_cnt <= err_cnt + 1'b1;
      end
    end
  end

endmodule

/* rtl/sort_top.sv */
// Packet sorter top level
// Enqueue, sort engine, dequeue and the register block

`timescale 1ns/1ps

`include "sort_settings.svh"

module sort_top (
    input  logic                 clk
  , input  logic                 rst_n
  , input  logic                 in_vld
  , input  logic                 in_sop
  , input  logic                 in_eop
  , input  sort_pkg::w_t         in_dat
  , output logic                 in_rdy
  , output logic                 out_vld
  , output logic                 out_sop
  , output logic                 out_eop
  , output logic                 out_err
  , output sort_pkg::w_t         out_dat
  , input  logic                 wb_cyc
  , input  logic                 wb_stb
  , input  logic                 wb_we
  , input  logic [`CSR_AW-1:0]   wb_adr
  , input  logic [31:0]          wb_dat_w
  , output logic [31:0]          wb_dat_r
  , output logic                 wb_ack
);

  // Control from the register block
  logic enable;
  logic descend;

  // Enqueue to engine
  logic               wr_en;
  sort_pkg::bank_id_t wr_bank;
  sort_pkg::addr_t    wr_addr;
  sort_pkg::w_t       wr_dat;
  logic               fill_start;
  logic               fill_done;
  sort_pkg::bank_id_t fill_bank;
  sort_pkg::len_t     fill_len;
  logic               fill_err;

  // Shared bank status
  sort_pkg::bank_status_t [`SORT_BANKS-1:0] bank_status;

  // Dequeue to engine
  sort_pkg::bank_id_t deq_bank;
  logic               unload_start;
  logic               unload_done;
  logic               rd_en;
  sort_pkg::addr_t    rd_addr;
  sort_pkg::w_t       rd_dat;
  sort_pkg::len_t     bank_len;
  logic               bank_err;

  // Counter events
  logic pkt_done;
  logic pkt_err;

  sort_enq sort_enq_i (.*);

  sort_engine sort_engine_i (.*);

  sort_deq sort_deq_i (.*);

  sort_csr sort_csr_i (.*);

endmodule

/* tests/tb_clock.sv */
// Testbench clock source
// Free-running clock, low at time zero

`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

/* tests/sort_tb.sv */
// Packet sorter testbench
// Sends a table of packets, predicts the sorted output with a
// reference model and checks the output stream and the registers

`timescale 1ns/1ps

`include "sort_settings.svh"

module sort_tb;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_PKTS   = 9;

  // Packet table: length, descending, random data
  localparam int   PKT_LEN  [NUM_PKTS] = '{5, 8, 1, 12, 3, 8, 6, 10, 2};
  localparam logic PKT_DESC [NUM_PKTS] = '{0, 0, 0, 0, 0, 1, 1, 1, 1};
  localparam logic PKT_RAND [NUM_PKTS] = '{0, 1, 1, 1, 0, 0, 1, 1, 0};

  logic               clk;
  logic               rst_n;
  logic               in_vld;
  logic               in_sop;
  logic               in_eop;
  sort_pkg::w_t       in_dat;
  logic               in_rdy;
  logic               out_vld;
  logic               out_sop;
  logic               out_eop;
  logic               out_err;
  sort_pkg::w_t       out_dat;
  logic               wb_cyc;
  logic               wb_stb;
  logic               wb_we;
  logic [`CSR_AW-1:0] wb_adr;
  logic [31:0]        wb_dat_w;
  logic [31:0]        wb_dat_r;
  logic               wb_ack;

  // Expected output, one entry per word
  sort_pkg::w_t exp_dat [$];
  logic         exp_sop [$];
  logic         exp_eop [$];
  logic         exp_err [$];

  logic in_pkt;
  int   stalls;

  tb_clock #(.PERIOD_NS(CLK_PERIOD)) clock_i (.clk(clk));

  sort_top sort_top_i (.*);

  task automatic fail_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_word(input string name, input sort_pkg::w_t exp,
                            input sort_pkg::w_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %0b, got %0b", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      fail_run();
    end
  endtask

  // CTRL value with enable and direction bits
  function automatic logic [31:0] ctrl_word(input logic en, input logic desc);
    logic [31:0] v;
    v = '0;
    v[csr_pkg::CTRL_ENABLE_BIT]  = en;
    v[csr_pkg::CTRL_DESCEND_BIT] = desc;
    return v;
  endfunction

  // STATUS with every bank READY
  function automatic logic [31:0] ready_status();
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < `SORT_BANKS; b++) begin
      v[4*b +: 4] = {1'b0, sort_pkg::BANK_READY};
    end
    return v;
  endfunction

  function automatic int overflow_count();
    int n;
    n = 0;
    for (int p = 0; p < NUM_PKTS; p++) begin
      if (PKT_LEN[p] > `SORT_N) begin
        n++;
      end
    end
    return n;
  endfunction

  // Generous bound, the sort is quadratic in length
  function automatic int run_budget_cycles();
    int total;
    total = 0;
    for (int p = 0; p < NUM_PKTS; p++) begin
      total += PKT_LEN[p] * PKT_LEN[p] + 4 * PKT_LEN[p] + 50;
    end
    return total;
  endfunction

  // Classic cycle, driven on the falling edge until ack
  task automatic wb_write(input csr_pkg::csr_addr_t adr, input logic [31:0] dat);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = dat;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input csr_pkg::csr_addr_t adr, output logic [31:0] dat);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    dat    = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // Reference model then stimulus for one packet
  task automatic apply_packet(input int len, input logic desc, input logic rnd);
    sort_pkg::w_t words [$];
    sort_pkg::w_t kept [$];
    sort_pkg::w_t tmp;
    int           n;
    for (int k = 0; k < len; k++) begin
      if (rnd) begin
        words.push_back(sort_pkg::w_t'($urandom));
      end else begin
        // Small value range, gives duplicates
        words.push_back(sort_pkg::w_t'((k * 7 + 3) % 5));
      end
    end
    // Bank keeps only the first SORT_N words
    n = (len > `SORT_N) ? `SORT_N : len;
    for (int k = 0; k < n; k++) begin
      kept.push_back(words[k]);
    end
    // Insertion sort in the chosen direction
    for (int a = 1; a < n; a++) begin
      for (int b = a; b > 0; b--) begin
        if (desc ? (kept[b-1] < kept[b]) : (kept[b-1] > kept[b])) begin
          tmp       = kept[b-1];
          kept[b-1] = kept[b];
          kept[b]   = tmp;
        end
      end
    end
    for (int k = 0; k < n; k++) begin
      exp_dat.push_back(kept[k]);
      exp_sop.push_back(k == 0);
      exp_eop.push_back(k == n - 1);
      exp_err.push_back((k == n - 1) && (len > `SORT_N));
    end
    // Hold each word until in_rdy
    for (int k = 0; k < len; k++) begin
      in_vld = 1'b1;
      in_sop = (k == 0);
      in_eop = (k == len - 1);
      in_dat = words[k];
      while (!in_rdy) begin
        stalls++;
        @(negedge clk);
      end
      @(negedge clk);
    end
    in_vld = 1'b0;
    in_sop = 1'b0;
    in_eop = 1'b0;
  endtask

  task automatic drain_output();
    while (exp_dat.size() != 0 || in_pkt) @(negedge clk);
  endtask

  // Output monitor, outputs are registered so stable here
  always @(negedge clk) begin
    if (rst_n) begin
      if (out_vld) begin
        if (exp_dat.size() == 0) begin
          $display("Output word at %0t with no packet pending", $time);
          fail_run();
        end else begin
          check_word("out_dat", exp_dat[0], out_dat);
          check_flag("out_sop", exp_sop[0], out_sop);
          check_flag("out_eop", exp_eop[0], out_eop);
          check_flag("out_err", exp_err[0], out_err);
          void'(exp_dat.pop_front());
          void'(exp_sop.pop_front());
          void'(exp_eop.pop_front());
          void'(exp_err.pop_front());
          in_pkt = !out_eop;
        end
      end else if (in_pkt) begin
        $display("Gap inside an output packet at %0t", $time);
        fail_run();
      end
    end
  end

  // Watchdog
  initial begin
    #(run_budget_cycles() * CLK_PERIOD);
    $display("Timeout: the output stream never finished all packets");
    fail_run();
  end

  initial begin
    logic [31:0] rd;
    logic        cur_desc;
    rst_n    = 1'b0;
    in_vld   = 1'b0;
    in_sop   = 1'b0;
    in_eop   = 1'b0;
    in_dat   = '0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    in_pkt   = 1'b0;
    stalls   = 0;
    void'($urandom(32'hf01f_7969));

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Idle after reset
    check_flag("out_vld", 1'b0, out_vld);
    check_flag("wb_ack", 1'b0, wb_ack);
    check_flag("in_rdy", 1'b0, in_rdy);
    wb_read(csr_pkg::CSR_CTRL, rd);
    check_reg("CTRL", 32'h0, rd);
    wb_read(csr_pkg::CSR_STATUS, rd);
    check_reg("STATUS", ready_status(), rd);

    // Enable, ascending
    cur_desc = 1'b0;
    wb_write(csr_pkg::CSR_CTRL, ctrl_word(1'b1, cur_desc));
    wb_read(csr_pkg::CSR_CTRL, rd);
    check_reg("CTRL", ctrl_word(1'b1, cur_desc), rd);
    check_flag("in_rdy", 1'b1, in_rdy);

    for (int p = 0; p < NUM_PKTS; p++) begin
      // Direction only changes with the pipe empty
      if (PKT_DESC[p] != cur_desc) begin
        drain_output();
        cur_desc = PKT_DESC[p];
        wb_write(csr_pkg::CSR_CTRL, ctrl_word(1'b1, cur_desc));
        wb_read(csr_pkg::CSR_CTRL, rd);
        check_reg("CTRL", ctrl_word(1'b1, cur_desc), rd);
      end
      apply_packet(PKT_LEN[p], PKT_DESC[p], PKT_RAND[p]);
    end
    drain_output();
    repeat (4) @(negedge clk);

    // Counters and final bank state
    wb_read(csr_pkg::CSR_PKT_COUNT, rd);
    check_reg("PKT_COUNT", 32'(NUM_PKTS), rd);
    wb_read(csr_pkg::CSR_ERR_COUNT, rd);
    check_reg("ERR_COUNT", 32'(overflow_count()), rd);
    wb_read(csr_pkg::CSR_STATUS, rd);
    check_reg("STATUS", ready_status(), rd);

    if (stalls == 0) begin
      $display("Input never stalled while packets were sent back to back");
      fail_run();
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

/* verilog.f */
+incdir+rtl
rtl/sort_pkg.sv
rtl/csr_pkg.sv
rtl/sort_enq.sv
rtl/sort_engine.sv
rtl/sort_deq.sv
rtl/sort_csr.sv
rtl/sort_top.sv
tests/tb_clock.sv
tests/sort_tb.sv

/* Makefile */
# Verilator build and run of the packet sorter testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fails unless it passes"
	@echo "  clean  remove the Verilator build directory"

obj_dir/Vsort_tb: verilog.f rtl/sort_settings.svh rtl/*.sv tests/*.sv
	verilator --binary --timing --assert -f verilog.f \
		--top-module sort_tb -o Vsort_tb

# Pass only when the run prints the pass line
test: obj_dir/Vsort_tb
	@out="$$(./obj_dir/Vsort_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
